// File: verif/fetch_stim.txt
// mode exc exc_pc res_vld res_pc res_tgt res_tkn res_misp exp_vld exp_pc exp_ptkn exp_ptgt
// mode 0/1 is mem_ready, 2 draws it at random, e ends; exp_pc and prediction after the edge
// Sequential steps from the boot address
1 0 00000000 0 00000000 00000000 0 0 1 00000104 0 00000000
1 0 00000000 0 00000000 00000000 0 0 1 00000108 0 00000000
1 0 00000000 0 00000000 00000000 0 0 1 0000010c 0 00000000
// Memory stall holds the PC
0 0 00000000 0 00000000 00000000 0 0 1 0000010c 0 00000000
0 0 00000000 0 00000000 00000000 0 0 1 0000010c 0 00000000
1 0 00000000 0 00000000 00000000 0 0 1 00000110 0 00000000
// Exception during a stall is lost
0 1 00000400 0 00000000 00000000 0 0 0 00000110 0 00000000
// Exception redirect, then exception beats a misprediction
1 1 00000300 0 00000000 00000000 0 0 0 00000300 0 00000000
1 1 00000380 1 00000524 00000600 1 1 0 00000380 0 00000000
1 0 00000000 0 00000000 00000000 0 0 1 00000384 0 00000000
// Taken misprediction, then not-taken misprediction
1 0 00000000 1 000003a0 000001c0 1 1 0 000001c0 0 00000000
1 0 00000000 0 00000000 00000000 0 0 1 000001c4 0 00000000
1 0 00000000 1 000003b0 000003e0 0 1 0 000003b4 0 00000000
1 0 00000000 0 00000000 00000000 0 0 1 000003b8 0 00000000
// Two taken resolutions of 0x140 train the predictor
1 0 00000000 1 00000140 00000200 1 0 0 000003bc 0 00000000
1 0 00000000 1 00000140 00000200 1 0 0 000003c0 0 00000000
// Walk up to the trained branch
1 1 00000138 0 00000000 00000000 0 0 0 00000138 0 00000000
1 0 00000000 0 00000000 00000000 0 0 1 0000013c 0 00000000
1 0 00000000 0 00000000 00000000 0 0 1 00000140 1 00000200
1 0 00000000 0 00000000 00000000 0 0 1 00000200 0 00000000
1 0 00000000 0 00000000 00000000 0 0 1 00000204 0 00000000
// Two not-taken resolutions, the second under a stall
1 0 00000000 1 00000140 00000200 0 0 0 00000208 0 00000000
0 0 00000000 1 00000140 00000200 0 0 0 00000208 0 00000000
// Back at the branch, now falls through
1 1 0000013c 0 00000000 00000000 0 0 0 0000013c 0 00000000
1 0 00000000 0 00000000 00000000 0 0 1 00000140 0 00000000
1 0 00000000 0 00000000 00000000 0 0 1 00000144 0 00000000
1 0 00000000 0 00000000 00000000 0 0 1 00000148 0 00000000
// Random back-pressure filler
2 0 00000000 0 00000000 00000000 0 0 1 00000000 0 00000000
2 0 00000000 0 00000000 00000000 0 0 1 00000000 0 00000000
2 0 00000000 0 00000000 00000000 0 0 1 00000000 0 00000000
2 0 00000000 0 00000000 00000000 0 0 1 00000000 0 00000000
2 0 00000000 0 00000000 00000000 0 0 1 00000000 0 00000000
2 0 00000000 0 00000000 00000000 0 0 1 00000000 0 00000000
2 0 00000000 0 00000000 00000000 0 0 1 00000000 0 00000000
2 0 00000000 0 00000000 00000000 0 0 1 00000000 0 00000000
// End of stimulus
e

// File: sim.f
hdl/fetch_pkg.sv
hdl/pred_if.sv
hdl/res_if.sv
hdl/pc_gen.sv
hdl/branch_predictor.sv
hdl/fetch_top.sv
verif/tb_clk_gen.sv
verif/tb_fetch.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the fetch stage testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_fetch -f sim.f \
    && ./obj_dir/Vtb_fetch | tee /dev/stderr | grep -x "TEST PASS" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: verif/tb_fetch.sv
`timescale 1ns/1ps
// ----------------------------------------
// Fetch address stage testbench
// Replays stimulus vectors from a file and
// checks PC, valid and prediction outputs
// ----------------------------------------

module tb_fetch;
    import fetch_pkg::*;

    // ----------------------------------------
    // Setup
    // ----------------------------------------

    localparam addr_t BOOT_PC = 32'h0000_0100;

    // Words per stimulus line and field positions
    localparam int FIELDS      = 12;
    localparam int F_MODE      = 0;
    localparam int F_EXC       = 1;
    localparam int F_EXC_PC    = 2;
    localparam int F_RES_VLD   = 3;
    localparam int F_RES_PC    = 4;
    localparam int F_RES_TGT   = 5;
    localparam int F_RES_TKN   = 6;
    localparam int F_RES_MISP  = 7;
    localparam int F_EXP_VLD   = 8;
    localparam int F_EXP_PC    = 9;
    localparam int F_EXP_PTKN  = 10;
    localparam int F_EXP_PTGT  = 11;

    // Stimulus memory geometry
    localparam int MEM_AW      = 10;
    localparam int MEM_DEPTH   = 1024;
    localparam int MAX_LINES   = MEM_DEPTH / FIELDS;

    // Mode column codes
    localparam logic [31:0] MODE_RANDOM = 32'h2;
    localparam logic [31:0] MODE_END    = 32'he;

    // DUT inputs
    logic  clk_i;
    logic  rst_n_i;
    logic  comm_except_raised_i;
    addr_t comm_except_pc_i;
    logic  comm_res_valid_i;
    addr_t comm_res_pc_i;
    addr_t comm_res_target_i;
    logic  comm_res_taken_i;
    logic  comm_res_mispredict_i;
    logic  mem_ready_i;

    // DUT outputs
    logic  valid_o;
    logic  comm_ready_o;
    addr_t pc_o;
    logic  pred_taken_o;
    addr_t pred_target_o;

    logic [31:0] stim_mem [0:MEM_DEPTH-1];
    int          num_lines;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;
    integer      seed;

    tb_clk_gen u_clk_gen (
        .clk_o   (clk_i),
        .rst_n_o (rst_n_i)
    );

    fetch_top #(
        .BOOT_PC (BOOT_PC)
    ) uut (
        .clk_i                 (clk_i),
        .rst_n_i               (rst_n_i),
        .comm_except_raised_i  (comm_except_raised_i),
        .comm_except_pc_i      (comm_except_pc_i),
        .comm_res_valid_i      (comm_res_valid_i),
        .comm_res_pc_i         (comm_res_pc_i),
        .comm_res_target_i     (comm_res_target_i),
        .comm_res_taken_i      (comm_res_taken_i),
        .comm_res_mispredict_i (comm_res_mispredict_i),
        .mem_ready_i           (mem_ready_i),
        .valid_o               (valid_o),
        .comm_ready_o          (comm_ready_o),
        .pc_o                  (pc_o),
        .pred_taken_o          (pred_taken_o),
        .pred_target_o         (pred_target_o)
    );

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // One word of one stimulus line
    function automatic logic [31:0] get_field(input int row, input int idx);
        logic [MEM_AW-1:0] addr;
        addr = MEM_AW'(row * FIELDS + idx);
        return stim_mem[addr];
    endfunction

    // Lines before the end marker or zero without one
    function automatic int count_lines();
        for (int row = 0; row < MAX_LINES; row++) begin
            if (get_field(row, F_MODE) == MODE_END) begin
                return row;
            end
        end
        return 0;
    endfunction

    task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected 'h%08h, actual 'h%08h",
                     $time, name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "Address mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected %b, actual %b",
                     $time, name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "Bit mismatch on %s", name);
        end
    endtask

    // Commit and memory inputs for one cycle
    task automatic drive_line(input int row, input logic ready);
        logic [31:0] w;
        mem_ready_i           = ready;
        w                     = get_field(row, F_EXC);
        comm_except_raised_i  = w[0];
        comm_except_pc_i      = get_field(row, F_EXC_PC);
        w                     = get_field(row, F_RES_VLD);
        comm_res_valid_i      = w[0];
        comm_res_pc_i         = get_field(row, F_RES_PC);
        comm_res_target_i     = get_field(row, F_RES_TGT);
        w                     = get_field(row, F_RES_TKN);
        comm_res_taken_i      = w[0];
        w                     = get_field(row, F_RES_MISP);
        comm_res_mispredict_i = w[0];
    endtask

    // ----------------------------------------
    // Cycle limit
    // ----------------------------------------

    always @(posedge clk_i) begin
        if (rst_n_i) begin
            cycle_cnt <= cycle_cnt + 1;
            if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
                $display("Timeout after %0d cycles, stimulus did not complete", cycle_cnt);
                $display("TEST FAIL");
                $fatal(1, "Cycle limit reached");
            end
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        logic [31:0] w;
        logic [31:0] rnd;
        logic        ready;
        logic        want_ptkn;
        addr_t       want_pc;
        addr_t       exp_pc;

        seed                  = 32'h4952aaf0;
        comm_except_raised_i  = 1'b0;
        comm_except_pc_i      = '0;
        comm_res_valid_i      = 1'b0;
        comm_res_pc_i         = '0;
        comm_res_target_i     = '0;
        comm_res_taken_i      = 1'b0;
        comm_res_mispredict_i = 1'b0;
        mem_ready_i           = 1'b0;

        $readmemh("verif/fetch_stim.txt", stim_mem);
        num_lines = count_lines();
        if (num_lines == 0) begin
            $display("Stimulus file is empty or has no end marker");
            $display("TEST FAIL");
            $fatal(1, "No stimulus");
        end
        cycle_limit = num_lines + 20;

        // No fetch while in reset
        #1;
        check_bit("valid_o", 1'b0, valid_o);
        wait (rst_n_i === 1'b1);
        check_addr("pc_o", BOOT_PC, pc_o);
        exp_pc = BOOT_PC;

        for (int row = 0; row < num_lines; row++) begin
            @(negedge clk_i);
            w = get_field(row, F_MODE);
            if (w == MODE_RANDOM) begin
                rnd   = $random(seed);
                ready = rnd[0];
            end else begin
                ready = w[0];
            end
            drive_line(row, ready);

            // Combinational outputs mid low phase
            #2;
            w = get_field(row, F_EXP_VLD);
            check_bit("valid_o", w[0], valid_o);
            check_bit("comm_ready_o", ready, comm_ready_o);

            // Filler lines step or hold from the last expected PC
            if (get_field(row, F_MODE) == MODE_RANDOM) begin
                want_pc = ready ? exp_pc + 32'd4 : exp_pc;
            end else begin
                want_pc = get_field(row, F_EXP_PC);
            end
            w         = get_field(row, F_EXP_PTKN);
            want_ptkn = w[0];

            @(posedge clk_i);
            #1;
            check_addr("pc_o", want_pc, pc_o);
            check_bit("pred_taken_o", want_ptkn, pred_taken_o);
            // Target only meaningful on a taken prediction
            if (want_ptkn) begin
                check_addr("pred_target_o", get_field(row, F_EXP_PTGT), pred_target_o);
            end
            exp_pc = want_pc;
        end

        @(negedge clk_i);
        mem_ready_i      = 1'b0;
        comm_res_valid_i = 1'b0;

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps
// ----------------------------------------
// Testbench clock and reset source
// 10 ns clock, reset low for two cycles
// ----------------------------------------

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);

    // Free running clock, starts low
    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Release on a falling edge, clear of the DUT's sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// File: hdl/fetch_top.sv
`timescale 1ns/1ps
// ----------------------------------------
// Fetch address stage top level
// PC generator with a bimodal predictor
// ----------------------------------------

module fetch_top #(
    parameter fetch_pkg::addr_t BOOT_PC      = '0,
    parameter int unsigned      BPU_IDX_BITS = 4
) (
    input  logic             clk_i,
    input  logic             rst_n_i,

    // Exception redirect from commit
    input  logic             comm_except_raised_i,
    input  fetch_pkg::addr_t comm_except_pc_i,

    // Branch resolution from commit
    input  logic             comm_res_valid_i,
    input  fetch_pkg::addr_t comm_res_pc_i,
    input  fetch_pkg::addr_t comm_res_target_i,
    input  logic             comm_res_taken_i,
    input  logic             comm_res_mispredict_i,

    // Instruction memory
    input  logic             mem_ready_i,
    output logic             valid_o,
    output logic             comm_ready_o,
    output fetch_pkg::addr_t pc_o,

    // Prediction for the instruction queue
    output logic             pred_taken_o,
    output fetch_pkg::addr_t pred_target_o
);

    // ----------------------------------------
    // Internal buses
    // ----------------------------------------

    pred_if pred_bus ();
    res_if  res_bus ();

    // Commit resolution onto the shared bus
    assign res_bus.valid      = comm_res_valid_i;
    assign res_bus.pc         = comm_res_pc_i;
    assign res_bus.target     = comm_res_target_i;
    assign res_bus.taken      = comm_res_taken_i;
    assign res_bus.mispredict = comm_res_mispredict_i;

    // Prediction travels with the fetched address
    assign pred_taken_o  = pred_bus.taken;
    assign pred_target_o = pred_bus.target;

    // ----------------------------------------
    // Instances
    // ----------------------------------------

    pc_gen #(
        .BOOT_PC (BOOT_PC)
    ) u_pc_gen (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .comm_except_raised_i (comm_except_raised_i),
        .comm_except_pc_i     (comm_except_pc_i),
        .res                  (res_bus),
        .pred                 (pred_bus),
        .mem_ready_i          (mem_ready_i),
        .valid_o              (valid_o),
        .comm_ready_o         (comm_ready_o),
        .pc_o                 (pc_o)
    );

    branch_predictor #(
        .BPU_IDX_BITS (BPU_IDX_BITS)
    ) u_branch_predictor (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .pred    (pred_bus),
        .res     (res_bus)
    );

endmodule

// File: hdl/branch_predictor.sv
`timescale 1ns/1ps
// ----------------------------------------
// Bimodal branch predictor
// Direct-mapped BTB with 2-bit counters
// Combinational lookup and training at commit
// ----------------------------------------

module branch_predictor #(
    parameter int unsigned BPU_IDX_BITS = 4
) (
    input  logic clk_i,
    input  logic rst_n_i,
    pred_if.bpu  pred,
    res_if.bpu   res
);
    import fetch_pkg::*;

    // ----------------------------------------
    // Geometry
    // ----------------------------------------

    localparam int unsigned NUM_ENTRIES = 2 ** BPU_IDX_BITS;
    // Index starts above the byte offset
    localparam int unsigned IDX_LSB     = 2;
    localparam int unsigned TAG_LSB     = IDX_LSB + BPU_IDX_BITS;
    localparam int unsigned TAG_BITS    = XLEN - TAG_LSB;

    typedef logic [BPU_IDX_BITS-1:0] idx_t;
    typedef logic [TAG_BITS-1:0]     tag_t;

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    // BTB valid bits
    logic [NUM_ENTRIES-1:0] btb_valid_q;
    // BTB tags and targets
    tag_t                   btb_tag_q    [NUM_ENTRIES];
    addr_t                  btb_target_q [NUM_ENTRIES];
    // Direction counters
    bht_cnt_t               bht_q        [NUM_ENTRIES];

    // Lookup side
    idx_t     lkp_idx;
    tag_t     lkp_tag;
    bht_cnt_t lkp_cnt;

    // Training side
    idx_t     res_idx;
    tag_t     res_tag;
    bht_cnt_t res_cnt;
    bht_cnt_t res_cnt_next;

    // ----------------------------------------
    // Lookup
    // ----------------------------------------

    assign lkp_idx = pred.lookup_pc[TAG_LSB-1:IDX_LSB];
    assign lkp_tag = pred.lookup_pc[XLEN-1:TAG_LSB];
    assign lkp_cnt = bht_q[lkp_idx];

    // Hit needs a valid entry with matching tag
    assign pred.hit    = btb_valid_q[lkp_idx] && (btb_tag_q[lkp_idx] == lkp_tag);
    // Taken only on a hit with a taken counter
    assign pred.taken  = pred.hit && (lkp_cnt == CNT_WT || lkp_cnt == CNT_ST);
    assign pred.target = btb_target_q[lkp_idx];

    // ----------------------------------------
    // Training
    // ----------------------------------------

    assign res_idx = res.pc[TAG_LSB-1:IDX_LSB];
    assign res_tag = res.pc[XLEN-1:TAG_LSB];
    assign res_cnt = bht_q[res_idx];

    // Saturating counter step
    always_comb begin
        res_cnt_next = res_cnt;
        case (res_cnt)
            CNT_SNT: begin
                res_cnt_next = res.taken ? CNT_WNT : CNT_SNT;
            end
            CNT_WNT: begin
                res_cnt_next = res.taken ? CNT_WT : CNT_SNT;
            end
            CNT_WT: begin
                res_cnt_next = res.taken ? CNT_ST : CNT_WNT;
            end
            CNT_ST: begin
                res_cnt_next = res.taken ? CNT_ST : CNT_WT;
            end
            default: begin
                res_cnt_next = CNT_WNT;
            end
        endcase
    end

    // Counters and valid bits
    // Every resolution updates its counter
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            btb_valid_q <= '0;
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                bht_q[i] <= CNT_WNT;
            end
        end else if (res.valid) begin
            bht_q[res_idx] <= res_cnt_next;
            // Only taken branches allocate in the BTB
            if (res.taken) begin
                btb_valid_q[res_idx] <= 1'b1;
            end
        end
    end

    // BTB payload written with the valid bit
    always_ff @(posedge clk_i) begin
        if (res.valid && res.taken) begin
            btb_tag_q[res_idx]    <= res_tag;
            btb_target_q[res_idx] <= res.target;
        end
    end

    // ----------------------------------------
    // Assertions
    // ----------------------------------------

    // Taken predictions steer fetch to a word-aligned target
    a_taken_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pred.taken |-> pred.target[1:0] == 2'b00
    );

    // Fresh tables predict nothing
    a_reset_not_taken: assert property (
        @(posedge clk_i)
        $rose(rst_n_i) |-> !pred.taken
    );

endmodule

// File: hdl/pc_gen.sv
`timescale 1ns/1ps
// ----------------------------------------
// Program counter generator
// Picks the next fetch address by priority
// and holds it while memory stalls
// ----------------------------------------

module pc_gen #(
    parameter fetch_pkg::addr_t BOOT_PC = '0
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             comm_except_raised_i,
    input  fetch_pkg::addr_t comm_except_pc_i,
    res_if.gen               res,
    pred_if.gen              pred,
    input  logic             mem_ready_i,

    output logic             valid_o,
    output logic             comm_ready_o,
    output fetch_pkg::addr_t pc_o
);
    import fetch_pkg::*;

    // Redirect from a wrong prediction
    logic  mispredict;
    // Shared adder operand and result
    addr_t add_pc;
    addr_t adder_out;
    // Selected next address
    addr_t next_pc;

    // ----------------------------------------
    // Next PC selection
    // ----------------------------------------

    assign mispredict = res.valid & res.mispredict;

    // One adder for both PC+4 paths
    assign add_pc    = mispredict ? res.pc : pc_o;
    assign adder_out = add_pc + addr_t'(INSTR_BYTES);

    // Exception, then misprediction, then prediction, then sequential
    always_comb begin
        if (comm_except_raised_i) begin
            next_pc = comm_except_pc_i;
        end else if (mispredict) begin
            // Not-taken branch resumes right after itself
            next_pc = res.taken ? res.target : adder_out;
        end else if (pred.taken) begin
            next_pc = pred.target;
        end else begin
            next_pc = adder_out;
        end
    end

    // ----------------------------------------
    // PC register
    // ----------------------------------------

    // Only advances when memory takes the address
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o <= BOOT_PC;
        end else if (mem_ready_i) begin
            pc_o <= next_pc;
        end
    end

    // Predictor looks up the address being fetched now
    assign pred.lookup_pc = pc_o;

    // Fetch is void while commit redirects or during reset
    assign valid_o      = rst_n_i & ~res.valid & ~comm_except_raised_i;
    // Commit must hold a redirect while memory stalls
    assign comm_ready_o = mem_ready_i;

    // ----------------------------------------
    // Assertions
    // ----------------------------------------

    // Boot, exception and trained targets all word aligned
    a_pc_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pc_o[1:0] == 2'b00
    );

    // A stalled cycle never moves the PC
    a_pc_hold: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !mem_ready_i |=> $stable(pc_o)
    );

endmodule

// File: hdl/res_if.sv
`timescale 1ns/1ps
// ----------------------------------------
// Commit branch resolution bus
// One resolved branch per valid strobe
// ----------------------------------------

interface res_if;
    import fetch_pkg::*;

    // One-cycle strobe
    logic  valid;
    // Address of the resolved branch
    addr_t pc;
    // Where the branch actually went
    addr_t target;
    // Actual outcome
    logic  taken;
    // Prediction for this branch was wrong
    logic  mispredict;

    // PC generator redirect view
    modport gen (
        input valid,
        input pc,
        input target,
        input taken,
        input mispredict
    );

    // Predictor training view
    // Trains on every resolution, so no mispredict flag
    modport bpu (
        input valid,
        input pc,
        input target,
        input taken
    );

endinterface

// File: hdl/pred_if.sv
`timescale 1ns/1ps
// ----------------------------------------
// Predictor lookup bus
// Current PC out to the predictor, prediction back
// ----------------------------------------

interface pred_if;
    import fetch_pkg::*;

    // Lookup address from the PC generator
    addr_t lookup_pc;

    // BTB entry valid with matching tag
    logic  hit;
    // Hit and counter in a taken state
    logic  taken;
    // Predicted next fetch address
    addr_t target;

    // PC generator side
    modport gen (
        output lookup_pc,
        input  taken,
        input  target
    );

    // Predictor side
    modport bpu (
        input  lookup_pc,
        output hit,
        output taken,
        output target
    );

endinterface

// File: hdl/fetch_pkg.sv
// ----------------------------------------
// Fetch stage shared definitions
// Address widths, PC step and predictor counter states
// ----------------------------------------

package fetch_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------

    // Address and data width
    localparam int unsigned XLEN = 32;

    // Instruction width, no compressed instructions
    localparam int unsigned ILEN = 32;

    // PC step in bytes for one instruction
    localparam int unsigned INSTR_BYTES = ILEN / 8;

    // ----------------------------------------
    // Types
    // ----------------------------------------

    // Program counters and branch targets
    typedef logic [XLEN-1:0] addr_t;

    // Bimodal 2-bit saturating counter
    // Upper bit set means predict taken
    typedef enum logic [1:0] {
        // Strong not-taken
        CNT_SNT = 2'b00,
        // Weak not-taken, the reset state
        CNT_WNT = 2'b01,
        // Weak taken
        CNT_WT  = 2'b10,
        // Strong taken
        CNT_ST  = 2'b11
    } bht_cnt_t;

endpackage
